// ==== include/rvc_params.svh ====
`ifndef RVC_PARAMS_SVH
`define RVC_PARAMS_SVH

// widths fixed by the ISA
`define RVC_INST_W 16
`define XLEN 32
`define REG_ADDR_W 5

// opcode field, bits 1:0
`define QUAD_0 2'd0
`define QUAD_1 2'd1
`define QUAD_2 2'd2
`define QUAD_FULL 2'd3 // uncompressed 32-bit encoding

// fixed registers of the expansions
`define REG_ZERO 5'd0
`define REG_RA 5'd1
`define REG_SP 5'd2

// 3-bit register fields address x8..x15
`define PRIME_REG_BASE 5'd8

`endif

// ==== rvc_decoder.f ====
+incdir+include
verilog/rvc_pkg.sv
verilog/rvc_imm_if.sv
verilog/rvc_field_decode.sv
verilog/rvc_imm_gen.sv
verilog/rvc_decode_reg.sv
verilog/rvc_decoder.sv
tests/rvc_decoder_tb.sv

// ==== tests/rvc_decoder_golden.txt ====
# word rs1 rs2 rd alu imm jt ctrl is_compressed, all hex
# ctrl = {wr_en, sel_op_a, sel_op_b, wb_sel[1:0], jump, store, load, branch, br_kind[1:0]}
0000 02 00 08 1 00000000 00000000 340 1  # zero word
14cc 02 00 0b 1 00000264 000000aa 740 1  # addi4spn x11, 0x264
ccf8 09 0e 00 1 0000005c 000000de 350 1  # sw x14, 0x5c(x9)
5575 00 00 0a 1 fffffffd ffffffec 740 1  # li x10, -3
2a55 00 00 01 1 00000015 000001b4 520 1  # jal +0x1b4
72f9 00 00 05 1 ffffe000 ffffffc6 580 1  # lui x5, 0x3e
7139 02 00 02 1 ffffffc0 ffffff46 740 1  # addi16sp -64
8e15 0c 0d 0c 2 00000005 0000003c 640 1  # sub x12, x13
c415 08 00 00 2 00000005 0000002c 246 1  # beqz x8, +0x2c
ffed 0f 00 00 2 fffffffb fffffffa 245 1  # bnez x15, -6
b7e9 00 00 00 1 fffffffa ffffffca 520 1  # j -0x36
539e 02 00 07 1 000000e4 00000026 7c8 1  # lwsp x7, 0xe4
df52 02 14 00 1 000000bc 0000009c 350 1  # swsp x20, 0xbc
8302 06 00 00 1 00000000 00000000 720 1  # jr x6
9582 0b 00 01 1 ffffffe0 ffffff08 720 1  # jalr x11
84c6 00 11 09 1 00000011 000000a8 640 1  # mv x9, x17
91fe 03 1f 03 1 ffffffff ffffffe6 640 1  # add x3, x31
0093 00 00 00 1 00000004 00000004 740 0  # low half of a 32-bit instruction

// ==== tests/rvc_decoder_tb.sv ====
module rvc_decoder_tb;

    logic        i_clk, i_rst, i_valid;
    logic [15:0] i_inst;
    logic        o_valid, o_is_compressed;
    logic [4:0]  o_rs1, o_rs2, o_rd;
    logic [3:0]  o_alu_op;
    logic [31:0] o_imm, o_jt;
    logic        o_wr_en, o_sel_op_a, o_sel_op_b;
    logic [1:0]  o_wb_sel;
    logic        o_is_jump, o_is_store, o_is_load, o_is_branch;
    logic [1:0]  o_br_kind;

    // expected decode per vector
    logic [15:0] vec_word [0:63];
    logic [4:0]  vec_rs1 [0:63];
    logic [4:0]  vec_rs2 [0:63];
    logic [4:0]  vec_rd [0:63];
    logic [3:0]  vec_alu [0:63];
    logic [31:0] vec_imm [0:63];
    logic [31:0] vec_jt [0:63];
    logic [10:0] vec_ctrl [0:63];
    logic        vec_isc [0:63];
    int          n_vec;
    logic [31:0] lfsr;
    int          cycles;
    logic [1:0]  gap;

    rvc_decoder u_dut (.*);

    always #4 i_clk = ~i_clk;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at time %0t: %s got %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic load_golden();
        int fd, n;
        string line;
        logic [15:0] w;
        logic [4:0] r1, r2, rd;
        logic [3:0] alu;
        logic [31:0] imm, jt;
        logic [10:0] ctrl;
        logic isc;
        fd = $fopen("tests/rvc_decoder_golden.txt", "r");
        if (fd == 0)
            abort_run("could not open the golden vector file");
        n_vec = 0;
        while (!$feof(fd) && n_vec < 64) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue; // blank or column notes
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", w, r1, r2, rd, alu, imm, jt,
                        ctrl, isc);
            if (n != 9)
                abort_run("malformed line in the golden vector file");
            vec_word[n_vec] = w;
            vec_rs1[n_vec] = r1;
            vec_rs2[n_vec] = r2;
            vec_rd[n_vec] = rd;
            vec_alu[n_vec] = alu;
            vec_imm[n_vec] = imm;
            vec_jt[n_vec] = jt;
            vec_ctrl[n_vec] = ctrl;
            vec_isc[n_vec] = isc;
            n_vec++;
        end
        $fclose(fd);
        if (n_vec == 0)
            abort_run("golden vector file holds no vectors");
    endtask

    task automatic check_outputs(input int idx);
        compare_value("is_compressed", o_is_compressed, vec_isc[idx]);
        compare_value("rs1", o_rs1, vec_rs1[idx]);
        compare_value("rs2", o_rs2, vec_rs2[idx]);
        compare_value("rd", o_rd, vec_rd[idx]);
        compare_value("alu_op", o_alu_op, vec_alu[idx]);
        compare_value("imm", o_imm, vec_imm[idx]);
        compare_value("jt", o_jt, vec_jt[idx]);
        compare_value("control flags", {o_wr_en, o_sel_op_a, o_sel_op_b, o_wb_sel, o_is_jump,
                      o_is_store, o_is_load, o_is_branch, o_br_kind}, vec_ctrl[idx]);
    endtask

    // strobe is dropped on the first falling edge
    task automatic wait_for_valid(output int n);
        n = 0;
        do begin
            @(negedge i_clk);
            i_valid = 1'b0;
            n++;
        end while (!o_valid && n < 10);
        if (!o_valid)
            abort_run("o_valid never arrived after a strobe");
    endtask

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        i_valid = 1'b0;
        i_inst = '0;
        lfsr = 32'h5c65;
        load_golden();

        repeat (2) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        compare_value("o_valid after reset", o_valid, 0);
        compare_value("o_wr_en after reset", o_wr_en, 0);
        compare_value("rd after reset", o_rd, 0);
        compare_value("imm after reset", o_imm, 0);
        compare_value("jt after reset", o_jt, 0);

        for (int idx = 0; idx < n_vec; idx++) begin
            i_inst = vec_word[idx]; // on a falling edge here
            i_valid = 1'b1;
            wait_for_valid(cycles);
            compare_value("o_valid latency", cycles, 1);
            check_outputs(idx);
            i_inst = ~vec_word[idx]; // other quadrant, must not be captured while idle
            lfsr = lfsr_step(lfsr);
            gap[0] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            gap[1] = lfsr[0];
            if (idx == n_vec - 1)
                gap = 2'd2;
            for (int g = 0; g < gap; g++) begin
                @(negedge i_clk);
                compare_value("o_valid while idle", o_valid, 0);
                check_outputs(idx); // last result held
            end
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verilog/rvc_decode_reg.sv ====
`include "rvc_params.svh"

module rvc_decode_reg (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  logic                    i_is_compressed,
    input  logic [`REG_ADDR_W-1:0]  i_rs1,
    input  logic [`REG_ADDR_W-1:0]  i_rs2,
    input  logic [`REG_ADDR_W-1:0]  i_rd,
    input  logic [3:0]              i_alu_op,
    input  logic [`XLEN-1:0]        i_imm,
    input  logic [`XLEN-1:0]        i_jt,
    input  logic [8:0]              i_ctrl,      // wr_en .. is_branch, see top
    input  logic [1:0]              i_br_kind,
    output logic                    o_valid,
    output logic                    o_is_compressed,
    output logic [`REG_ADDR_W-1:0]  o_rs1,
    output logic [`REG_ADDR_W-1:0]  o_rs2,
    output logic [`REG_ADDR_W-1:0]  o_rd,
    output logic [3:0]              o_alu_op,
    output logic [`XLEN-1:0]        o_imm,
    output logic [`XLEN-1:0]        o_jt,
    output logic [8:0]              o_ctrl,
    output logic [1:0]              o_br_kind
);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
            {o_is_compressed, o_rs1, o_rs2, o_rd, o_alu_op} <= '0;
            {o_imm, o_jt, o_ctrl, o_br_kind} <= '0;
        end else begin
            o_valid <= i_valid; // one-cycle pulse per strobe
            if (i_valid) begin
                // held until the next strobe
                {o_is_compressed, o_rs1, o_rs2, o_rd, o_alu_op} <=
                    {i_is_compressed, i_rs1, i_rs2, i_rd, i_alu_op};
                {o_imm, o_jt, o_ctrl, o_br_kind} <= {i_imm, i_jt, i_ctrl, i_br_kind};
            end
        end
    end

endmodule

// ==== verilog/rvc_decoder.sv ====
`include "rvc_params.svh"

module rvc_decoder (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_valid,
    input  logic [`RVC_INST_W-1:0]  i_inst,
    output logic                    o_valid,
    output logic                    o_is_compressed,
    output logic [`REG_ADDR_W-1:0]  o_rs1,
    output logic [`REG_ADDR_W-1:0]  o_rs2,
    output logic [`REG_ADDR_W-1:0]  o_rd,
    output logic [3:0]              o_alu_op,
    output logic [`XLEN-1:0]        o_imm,
    output logic [`XLEN-1:0]        o_jt,
    output logic                    o_wr_en,
    output logic                    o_sel_op_a,
    output logic                    o_sel_op_b,
    output logic [1:0]              o_wb_sel,
    output logic                    o_is_jump,
    output logic                    o_is_store,
    output logic                    o_is_load,
    output logic                    o_is_branch,
    output logic [1:0]              o_br_kind
);

    logic                   d_is_compressed;
    logic [`REG_ADDR_W-1:0] d_rs1, d_rs2, d_rd;
    logic [3:0]             d_alu_op;
    logic [`XLEN-1:0]       d_imm, d_jt;
    logic                   d_wr_en, d_sel_op_a, d_sel_op_b;
    logic [1:0]             d_wb_sel;
    logic                   d_is_jump, d_is_store, d_is_load, d_is_branch;
    logic [1:0]             d_br_kind;

    rvc_imm_if u_imm_if ();

    rvc_field_decode u_field_decode (
        .i_inst          (i_inst),
        .imm_if          (u_imm_if.producer),
        .o_is_compressed (d_is_compressed),
        .o_rs1           (d_rs1),
        .o_rs2           (d_rs2),
        .o_rd            (d_rd),
        .o_alu_op        (d_alu_op),
        .o_wr_en         (d_wr_en),
        .o_sel_op_a      (d_sel_op_a),
        .o_sel_op_b      (d_sel_op_b),
        .o_wb_sel        (d_wb_sel),
        .o_is_jump       (d_is_jump),
        .o_is_store      (d_is_store),
        .o_is_load       (d_is_load),
        .o_is_branch     (d_is_branch),
        .o_br_kind       (d_br_kind)
    );

    rvc_imm_gen u_imm_gen (
        .i_inst (i_inst),
        .imm_if (u_imm_if.consumer),
        .o_imm  (d_imm),
        .o_jt   (d_jt)
    );

    // control flags travel through the register as one 9-bit group
    rvc_decode_reg u_decode_reg (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_valid         (i_valid),
        .i_is_compressed (d_is_compressed),
        .i_rs1           (d_rs1),
        .i_rs2           (d_rs2),
        .i_rd            (d_rd),
        .i_alu_op        (d_alu_op),
        .i_imm           (d_imm),
        .i_jt            (d_jt),
        .i_ctrl          ({d_wr_en, d_sel_op_a, d_sel_op_b, d_wb_sel,
                           d_is_jump, d_is_store, d_is_load, d_is_branch}),
        .i_br_kind       (d_br_kind),
        .o_valid         (o_valid),
        .o_is_compressed (o_is_compressed),
        .o_rs1           (o_rs1),
        .o_rs2           (o_rs2),
        .o_rd            (o_rd),
        .o_alu_op        (o_alu_op),
        .o_imm           (o_imm),
        .o_jt            (o_jt),
        .o_ctrl          ({o_wr_en, o_sel_op_a, o_sel_op_b, o_wb_sel,
                           o_is_jump, o_is_store, o_is_load, o_is_branch}),
        .o_br_kind       (o_br_kind)
    );

endmodule

// ==== verilog/rvc_field_decode.sv ====
`include "rvc_params.svh"

module rvc_field_decode import rvc_pkg::*; (
    input  rvc_inst_u               i_inst,
    rvc_imm_if.producer             imm_if,
    output logic                    o_is_compressed,
    output logic [`REG_ADDR_W-1:0]  o_rs1,
    output logic [`REG_ADDR_W-1:0]  o_rs2,
    output logic [`REG_ADDR_W-1:0]  o_rd,
    output alu_op_e                 o_alu_op,
    output logic                    o_wr_en,
    output logic                    o_sel_op_a,
    output logic                    o_sel_op_b,
    output wb_sel_e                 o_wb_sel,
    output logic                    o_is_jump,
    output logic                    o_is_store,
    output logic                    o_is_load,
    output logic                    o_is_branch,
    output br_kind_t                o_br_kind
);

    logic j_type, jr_type, r_type, b_type, lui_type;
    logic load_inst, store_inst;
    logic spn_imm, sp16_imm, lssp_imm, unsigned_imm;

    // x8..x15 from a 3-bit field
    function automatic logic [`REG_ADDR_W-1:0] prime(input logic [2:0] r);
        return `PRIME_REG_BASE + {2'b00, r};
    endfunction

    always_comb begin
        o_rs1 = `REG_ZERO;
        o_rs2 = `REG_ZERO;
        o_rd = `REG_ZERO;
        o_alu_op = ALU_ADD;
        o_br_kind = '0;
        {j_type, jr_type, r_type, b_type, lui_type} = '0;
        {load_inst, store_inst} = '0;
        {spn_imm, sp16_imm, lssp_imm, unsigned_imm} = '0;

        case (i_inst.cr.op)
            `QUAD_0: begin
                case (i_inst.ciw.funct3)
                    3'd0: begin // ADDI4SPN, addi rd', x2, nzuimm
                        o_rd = prime(i_inst.ciw.rd_p);
                        o_rs1 = `REG_SP;
                        spn_imm = 1'b1;
                        unsigned_imm = 1'b1;
                    end
                    3'd2: begin // LW
                        o_rd = prime(i_inst.cl.rd_p);
                        o_rs1 = prime(i_inst.cl.rs1_p);
                        load_inst = 1'b1;
                        unsigned_imm = 1'b1;
                    end
                    3'd6: begin // SW
                        o_rs1 = prime(i_inst.cs.rs1_p);
                        o_rs2 = prime(i_inst.cs.rs2_p);
                        store_inst = 1'b1;
                        unsigned_imm = 1'b1;
                    end
                    default: ;
                endcase
            end
            `QUAD_1: begin
                case (i_inst.ci.funct3)
                    3'd0: begin // ADDI, NOP when rd is x0
                        o_rd = i_inst.ci.rd_rs1;
                        o_rs1 = i_inst.ci.rd_rs1;
                    end
                    3'd1: begin
                        o_rd = `REG_RA; // JAL links to x1
                        j_type = 1'b1;
                    end
                    3'd2: o_rd = i_inst.ci.rd_rs1; // LI, addi rd, x0, imm
                    3'd3: begin
                        if (i_inst.ci.rd_rs1 != `REG_SP) begin // LUI
                            o_rd = i_inst.ci.rd_rs1;
                            lui_type = 1'b1;
                        end else begin // ADDI16SP
                            o_rd = `REG_SP;
                            o_rs1 = `REG_SP;
                            sp16_imm = 1'b1;
                        end
                    end
                    3'd4: begin
                        o_rd = prime(i_inst.cb.rs1_p);
                        o_rs1 = prime(i_inst.cb.rs1_p);
                        case (i_inst.cb.funct2)
                            2'd0: begin
                                o_alu_op = ALU_SRL;
                                unsigned_imm = 1'b1;
                            end
                            2'd1: begin
                                o_alu_op = ALU_SRA;
                                unsigned_imm = 1'b1;
                            end
                            2'd2: o_alu_op = ALU_AND; // ANDI
                            default: begin
                                if (!i_inst.ca.funct6[2]) begin
                                    r_type = 1'b1;
                                    o_rs2 = prime(i_inst.ca.rs2_p);
                                    case (i_inst.ca.funct2_lo)
                                        2'd0: o_alu_op = ALU_SUB;
                                        2'd1: o_alu_op = ALU_XOR;
                                        2'd2: o_alu_op = ALU_OR;
                                        default: o_alu_op = ALU_AND;
                                    endcase
                                end
                            end
                        endcase
                    end
                    3'd5: j_type = 1'b1; // J, rd stays x0
                    default: begin // BEQZ / BNEZ compare rs1' against x0
                        o_rs1 = prime(i_inst.cb.rs1_p);
                        b_type = 1'b1;
                        o_alu_op = ALU_SUB;
                        o_br_kind.beqz = !i_inst.cb.funct3[0];
                        o_br_kind.bnez = i_inst.cb.funct3[0];
                    end
                endcase
            end
            `QUAD_2: begin
                case (i_inst.ci.funct3)
                    3'd0: begin // SLLI
                        o_rd = i_inst.ci.rd_rs1;
                        o_rs1 = i_inst.ci.rd_rs1;
                        o_alu_op = ALU_SLL;
                    end
                    3'd2: begin // LWSP
                        o_rd = i_inst.ci.rd_rs1;
                        o_rs1 = `REG_SP;
                        load_inst = 1'b1;
                        lssp_imm = 1'b1;
                        unsigned_imm = 1'b1;
                    end
                    3'd6: begin // SWSP
                        o_rs1 = `REG_SP;
                        o_rs2 = i_inst.css.rs2;
                        store_inst = 1'b1;
                        lssp_imm = 1'b1;
                        unsigned_imm = 1'b1;
                    end
                    3'd4: begin
                        if (i_inst.cr.rs2 == `REG_ZERO) begin
                            // JR / JALR; both fields zero with funct4[0] is EBREAK
                            if (!(i_inst.cr.funct4[0] && i_inst.cr.rd_rs1 == `REG_ZERO)) begin
                                jr_type = 1'b1;
                                o_rs1 = i_inst.cr.rd_rs1;
                                o_rd = i_inst.cr.funct4[0] ? `REG_RA : `REG_ZERO;
                            end
                        end else begin
                            // ADD reads rd, MV reads x0
                            r_type = 1'b1;
                            o_rd = i_inst.cr.rd_rs1;
                            o_rs1 = i_inst.cr.funct4[0] ? i_inst.cr.rd_rs1 : `REG_ZERO;
                            o_rs2 = i_inst.cr.rs2;
                        end
                    end
                    default: ;
                endcase
            end
            default: ; // full-width instruction, defaults only
        endcase
    end

    assign o_is_compressed = (i_inst.cr.op != `QUAD_FULL);
    assign o_wr_en = !(store_inst || b_type || i_inst == '0);
    assign o_sel_op_a = !(lui_type || j_type);   // 0 picks pc / zero path
    assign o_sel_op_b = !(r_type || b_type);     // 0 picks rs2
    assign o_wb_sel = (j_type || jr_type) ? WB_PC :
                      lui_type ? WB_IMM :
                      load_inst ? WB_MEM : WB_ALU;
    assign o_is_jump = j_type || jr_type;
    assign o_is_store = store_inst;
    assign o_is_load = load_inst;
    assign o_is_branch = b_type;

    assign imm_if.lui = lui_type;
    assign imm_if.jal = j_type;
    assign imm_if.load = load_inst;
    assign imm_if.store = store_inst;
    assign imm_if.spn = spn_imm;
    assign imm_if.sp16 = sp16_imm;
    assign imm_if.lssp = lssp_imm;
    assign imm_if.unsigned_imm = unsigned_imm;

endmodule

// ==== verilog/rvc_imm_gen.sv ====
`include "rvc_params.svh"

module rvc_imm_gen import rvc_pkg::*; (
    input  rvc_inst_u          i_inst,
    rvc_imm_if.consumer        imm_if,
    output logic [`XLEN-1:0]   o_imm,
    output logic [`XLEN-1:0]   o_jt
);

    logic sign;

    assign sign = i_inst.ci.imm_hi && !imm_if.unsigned_imm;

    always_comb begin
        if (imm_if.lui) begin
            // nzimm[17:12]
            o_imm = {{15{sign}}, i_inst.ci.imm_lo, 12'b0};
        end else if (imm_if.sp16) begin
            // nzimm[9|4|6|8:7|5]
            o_imm = {{23{sign}}, i_inst.ci.imm_lo[2:1], i_inst.ci.imm_lo[3],
                     i_inst.ci.imm_lo[0], i_inst.ci.imm_lo[4], 4'b0};
        end else if (imm_if.spn) begin
            // nzuimm[5:4|9:6|2|3]
            o_imm = {{22{sign}}, i_inst.ciw.imm[5:2], i_inst.ciw.imm[7:6],
                     i_inst.ciw.imm[0], i_inst.ciw.imm[1], 2'b0};
        end else if (imm_if.lssp && imm_if.load) begin
            o_imm = {{24{sign}}, i_inst.ci.imm_lo[1:0], i_inst.ci.imm_hi,
                     i_inst.ci.imm_lo[4:2], 2'b0};     // LWSP uimm[5|4:2|7:6]
        end else if (imm_if.lssp) begin
            o_imm = {{24{sign}}, i_inst.css.imm[1:0], i_inst.css.imm[5:2], 2'b0};
        end else if (imm_if.load || imm_if.store) begin
            // LW / SW uimm[5:3|2|6]
            o_imm = {{25{sign}}, i_inst.cl.imm_lo[0], i_inst.cl.imm_hi,
                     i_inst.cl.imm_lo[1], 2'b0};
        end else begin
            o_imm = {{26{sign}}, i_inst.ci.imm_hi, i_inst.ci.imm_lo}; // plain CI
        end
    end

    // jump target offset[11|4|9:8|10|6|7|3:1|5], branch offset[8|4:3|7:6|2:1|5]
    always_comb begin
        if (imm_if.jal) begin
            o_jt = {{21{sign}},
                    i_inst.cj.target[6],
                    i_inst.cj.target[8:7],
                    i_inst.cj.target[4],
                    i_inst.cj.target[5],
                    i_inst.cj.target[0],
                    i_inst.cj.target[9],
                    i_inst.cj.target[3:1],
                    1'b0};
        end else begin
            o_jt = {{24{sign}},
                    i_inst.cb.imm_lo[4:3],
                    i_inst.cb.imm_lo[0],
                    i_inst.cb.funct2,
                    i_inst.cb.imm_lo[2:1],
                    1'b0};
        end
    end

endmodule

// ==== verilog/rvc_imm_if.sv ====
interface rvc_imm_if;
    // immediate format flags, same cycle as the instruction word
    logic lui;
    logic jal;          // JAL and J, selects the CJ offset layout
    logic load;
    logic store;
    logic spn;          // ADDI4SPN
    logic sp16;         // ADDI16SP
    logic lssp;         // LWSP / SWSP
    logic unsigned_imm;

    modport producer (
        output lui, jal, load, store, spn, sp16, lssp, unsigned_imm
    );

    modport consumer (
        input lui, jal, load, store, spn, sp16, lssp, unsigned_imm
    );
endinterface

// ==== verilog/rvc_pkg.sv ====
package rvc_pkg;

    // one compressed word, decoded according to its format
    typedef union packed {
        struct packed {
            logic [3:0] funct4;
            logic [4:0] rd_rs1;
            logic [4:0] rs2;
            logic [1:0] op;
        } cr;
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;   // bit 12, sign of signed forms
            logic [4:0] rd_rs1;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } ci;
        struct packed {
            logic [2:0] funct3;
            logic [5:0] imm;
            logic [4:0] rs2;
            logic [1:0] op;
        } css;
        struct packed {
            logic [2:0] funct3;
            logic [7:0] imm;
            logic [2:0] rd_p;
            logic [1:0] op;
        } ciw;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1_p;
            logic [1:0] imm_lo;
            logic [2:0] rd_p;
            logic [1:0] op;
        } cl;
        struct packed {
            logic [2:0] funct3;
            logic [2:0] imm_hi;
            logic [2:0] rs1_p;
            logic [1:0] imm_lo;
            logic [2:0] rs2_p;
            logic [1:0] op;
        } cs;
        struct packed {
            logic [5:0] funct6;
            logic [2:0] rd_rs1_p;
            logic [1:0] funct2_lo;
            logic [2:0] rs2_p;
            logic [1:0] op;
        } ca;
        struct packed {
            logic [2:0] funct3;
            logic       imm_hi;
            logic [1:0] funct2;   // offset bits 4:3 on branches
            logic [2:0] rs1_p;
            logic [4:0] imm_lo;
            logic [1:0] op;
        } cb;
        struct packed {
            logic [2:0]  funct3;
            logic [10:0] target;
            logic [1:0]  op;
        } cj;
    } rvc_inst_u;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_AND = 4'd3,
        ALU_OR  = 4'd4,
        ALU_XOR = 4'd5,
        ALU_SLL = 4'd8,
        ALU_SRL = 4'd9,
        ALU_SRA = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_PC  = 2'd0,  // link address
        WB_ALU = 2'd1,
        WB_IMM = 2'd2,
        WB_MEM = 2'd3
    } wb_sel_e;

    typedef struct packed {
        logic beqz;
        logic bnez;
    } br_kind_t;

endpackage
